// ==== src/rv_pkg.sv ====
package rv_pkg;

	localparam int xlen = 32;            // Data word width
	localparam int imem_words = 1024;    // 4 KiB program space
	localparam int dmem_words = 1024;    // 4 KiB data space

	typedef logic [xlen-1:0] word_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [11:0] pc_t;           // Byte address into instruction memory
	typedef logic [9:0] dmem_addr_t;     // Word address, also the con port address
	typedef logic [3:0] byte_en_t;       // One enable per byte lane

	// Major opcodes, inst[6:0]
	localparam logic [6:0] op_reg = 7'h33;
	localparam logic [6:0] op_imm = 7'h13;
	localparam logic [6:0] op_lui = 7'h37;
	localparam logic [6:0] op_load = 7'h03;
	localparam logic [6:0] op_store = 7'h23;
	localparam logic [6:0] op_branch = 7'h63;

	// Branch conditions in funct3
	localparam logic [2:0] f3_beq = 3'b000;
	localparam logic [2:0] f3_bne = 3'b001;
	localparam logic [2:0] f3_blt = 3'b100;
	localparam logic [2:0] f3_bge = 3'b101;
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and
	} alu_op_t;

	// Write-back source
	typedef enum logic [1:0] {
		sel_alu = 2'd0,
		sel_imm = 2'd1,      // LUI
		sel_load = 2'd2
	} wb_sel_t;

	// Load/store size, same encoding as funct3
	typedef enum logic [2:0] {
		size_b = 3'd0,
		size_h = 3'd1,
		size_w = 3'd2,
		size_bu = 3'd4,
		size_hu = 3'd5
	} mem_size_t;

endpackage

// ==== src/rv_fetch.sv ====
module rv_fetch (
	input  logic clk,
	input  logic rst_n,
	input  logic run,
	input  logic stall,
	input  logic branch_taken,
	input  rv_pkg::pc_t branch_target,
	input  logic prog_we,
	input  rv_pkg::pc_t prog_addr,
	input  rv_pkg::word_t prog_data,
	output logic id_valid,
	output rv_pkg::word_t id_inst,
	output rv_pkg::pc_t id_pc
);
	import rv_pkg::*;

	word_t imem [imem_words];    // Program store
	pc_t pc;                     // Address being fetched this cycle
	logic advance;               // Fetch/decode register takes a new word

	assign advance = run && !stall && !branch_taken;

	// PC and decode valid
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
			id_valid <= 1'b0;
		end else if (branch_taken) begin
			pc <= branch_target;     // Redirect from execute
			id_valid <= 1'b0;        // Word fetched from the old path is dropped
		end else if (!stall) begin
			if (run)
				pc <= pc + 12'd4;
			id_valid <= run;         // Bubbles while halted
		end
	end

	// Synchronous read, so the word lands in decode one cycle after its PC
	always_ff @(posedge clk) begin
		if (prog_we && !run)
			imem[prog_addr[11:2]] <= prog_data;   // Load port only while halted
		if (advance) begin
			id_inst <= imem[pc[11:2]];
			id_pc <= pc;
		end
	end

endmodule

// ==== src/rv_decode.sv ====
module rv_decode (
	input  logic clk,
	input  logic rst_n,
	input  logic id_valid,
	input  rv_pkg::word_t id_inst,
	input  rv_pkg::pc_t id_pc,
	input  logic branch_taken,
	input  rv_pkg::word_t ex_result,
	input  logic rf_we,
	input  rv_pkg::reg_addr_t rf_waddr,
	input  rv_pkg::word_t rf_wdata,
	output logic stall,
	output logic ex_valid,
	output rv_pkg::alu_op_t ex_alu_op,
	output rv_pkg::word_t ex_op_a,
	output rv_pkg::word_t ex_op_b,
	output rv_pkg::word_t ex_store_data,
	output rv_pkg::word_t ex_imm,
	output rv_pkg::reg_addr_t ex_rd,
	output logic ex_wr_en,
	output rv_pkg::wb_sel_t ex_wb_sel,
	output logic ex_is_load,
	output logic ex_is_store,
	output logic ex_is_branch,
	output logic [2:0] ex_funct3,
	output rv_pkg::mem_size_t ex_mem_size,
	output rv_pkg::pc_t ex_pc
);
	import rv_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic funct7_5;              // Picks SUB and SRA
	reg_addr_t rs1, rs2, rd;
	word_t imm_i, imm_s, imm_b, imm_u;

	alu_op_t alu_op;
	word_t imm;
	wb_sel_t wb_sel;
	logic use_imm;               // Operand B is the immediate
	logic wr_en, is_load, is_store, is_branch;
	logic use_rs1, use_rs2;      // Source actually read, for the hazard check

	word_t rf [32];
	word_t rf_a, rf_b;
	logic ex_hit_a, ex_hit_b, wb_hit_a, wb_hit_b;
	word_t fwd_a, fwd_b;
	logic bubble;

	assign opcode = id_inst[6:0];
	assign funct3 = id_inst[14:12];
	assign funct7_5 = id_inst[30];
	assign rd = id_inst[11:7];
	assign rs1 = id_inst[19:15];
	assign rs2 = id_inst[24:20];

	assign imm_i = {{20{id_inst[31]}}, id_inst[31:20]};
	assign imm_s = {{20{id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
	assign imm_b = {{19{id_inst[31]}}, id_inst[31], id_inst[7], id_inst[30:25],
		id_inst[11:8], 1'b0};
	assign imm_u = {id_inst[31:12], 12'h000};

	// Register and immediate forms share the funct3 map
	function automatic alu_op_t f3_to_alu(input logic [2:0] f3, input logic alt);
		alu_op_t op;
		case (f3)
			3'd0: op = alt ? alu_sub : alu_add;
			3'd1: op = alu_sll;
			3'd2: op = alu_slt;
			3'd3: op = alu_sltu;
			3'd4: op = alu_xor;
			3'd5: op = alt ? alu_sra : alu_srl;
			3'd6: op = alu_or;
			default: op = alu_and;
		endcase
		return op;
	endfunction

	always_comb begin
		alu_op = alu_add;        // Address add for loads and stores
		imm = imm_i;
		wb_sel = sel_alu;
		use_imm = 1'b0;
		wr_en = 1'b0;
		is_load = 1'b0;
		is_store = 1'b0;
		is_branch = 1'b0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		case (opcode)
			op_reg: begin
				alu_op = f3_to_alu(funct3, funct7_5);
				wr_en = 1'b1;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
			end
			op_imm: begin
				alu_op = f3_to_alu(funct3, funct7_5 && funct3 == 3'd5);  // Only SRAI
				use_imm = 1'b1;
				wr_en = 1'b1;
				use_rs1 = 1'b1;
			end
			op_lui: begin
				imm = imm_u;
				wb_sel = sel_imm;
				wr_en = 1'b1;
			end
			op_load: begin
				use_imm = 1'b1;
				wr_en = 1'b1;
				wb_sel = sel_load;
				is_load = 1'b1;
				use_rs1 = 1'b1;
			end
			op_store: begin
				imm = imm_s;
				use_imm = 1'b1;
				is_store = 1'b1;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;      // Store data
			end
			op_branch: begin
				imm = imm_b;         // Target offset, compare uses rs2
				is_branch = 1'b1;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
			end
			default: ;               // Unknown opcode runs as a NOP
		endcase
	end

	always_ff @(posedge clk) begin
		if (rf_we)
			rf[rf_waddr] <= rf_wdata;
	end

	assign rf_a = (rs1 == '0) ? '0 : rf[rs1];   // x0 reads zero
	assign rf_b = (rs2 == '0) ? '0 : rf[rs2];

	// A load in execute has no value yet, that case stalls instead
	assign ex_hit_a = ex_valid && ex_wr_en && !ex_is_load && rs1 != '0 && ex_rd == rs1;
	assign ex_hit_b = ex_valid && ex_wr_en && !ex_is_load && rs2 != '0 && ex_rd == rs2;
	assign wb_hit_a = rf_we && rf_waddr == rs1;
	assign wb_hit_b = rf_we && rf_waddr == rs2;

	// Youngest producer first
	assign fwd_a = ex_hit_a ? ex_result : wb_hit_a ? rf_wdata : rf_a;
	assign fwd_b = ex_hit_b ? ex_result : wb_hit_b ? rf_wdata : rf_b;

	assign stall = id_valid && ex_valid && ex_is_load && ex_rd != '0 &&
		((use_rs1 && ex_rd == rs1) || (use_rs2 && ex_rd == rs2));
	assign bubble = !id_valid || stall || branch_taken;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_valid <= 1'b0;
			ex_wr_en <= 1'b0;
			ex_is_load <= 1'b0;
			ex_is_store <= 1'b0;
			ex_is_branch <= 1'b0;
		end else begin
			ex_valid <= !bubble;
			ex_wr_en <= wr_en && !bubble;
			ex_is_load <= is_load && !bubble;
			ex_is_store <= is_store && !bubble;
			ex_is_branch <= is_branch && !bubble;
		end
	end

	always_ff @(posedge clk) begin
		ex_alu_op <= alu_op;
		ex_op_a <= fwd_a;
		ex_op_b <= use_imm ? imm : fwd_b;
		ex_store_data <= fwd_b;
		ex_imm <= imm;
		ex_rd <= rd;
		ex_wb_sel <= wb_sel;
		ex_funct3 <= funct3;
		ex_mem_size <= mem_size_t'(funct3);
		ex_pc <= id_pc;
	end

endmodule

// ==== src/rv_execute.sv ====
module rv_execute (
	input  logic clk,
	input  logic rst_n,
	input  logic ex_valid,
	input  rv_pkg::alu_op_t ex_alu_op,
	input  rv_pkg::word_t ex_op_a,
	input  rv_pkg::word_t ex_op_b,
	input  rv_pkg::word_t ex_store_data,
	input  rv_pkg::word_t ex_imm,
	input  rv_pkg::reg_addr_t ex_rd,
	input  logic ex_wr_en,
	input  rv_pkg::wb_sel_t ex_wb_sel,
	input  logic ex_is_store,
	input  logic ex_is_branch,
	input  logic [2:0] ex_funct3,
	input  rv_pkg::mem_size_t ex_mem_size,
	input  rv_pkg::pc_t ex_pc,
	output logic branch_taken,
	output rv_pkg::pc_t branch_target,
	output rv_pkg::word_t ex_result,
	output rv_pkg::byte_en_t dm_we,
	output rv_pkg::dmem_addr_t dm_addr,
	output rv_pkg::word_t dm_wdata,
	output logic wb_valid,
	output rv_pkg::reg_addr_t wb_rd,
	output logic wb_wr_en,
	output rv_pkg::wb_sel_t wb_wb_sel,
	output rv_pkg::word_t wb_alu,
	output rv_pkg::word_t wb_imm,
	output rv_pkg::mem_size_t wb_mem_size,
	output logic [1:0] wb_byte_off
);
	import rv_pkg::*;

	word_t alu_out;
	logic [4:0] shamt;
	logic eq, lt, ltu;           // Shared by SLT/SLTU and the branch compare
	logic cond;
	byte_en_t store_be;
	logic [1:0] byte_off;

	assign shamt = ex_op_b[4:0];
	assign eq = ex_op_a == ex_op_b;
	assign lt = $signed(ex_op_a) < $signed(ex_op_b);
	assign ltu = ex_op_a < ex_op_b;

	always_comb begin
		case (ex_alu_op)
			alu_add: alu_out = ex_op_a + ex_op_b;
			alu_sub: alu_out = ex_op_a - ex_op_b;
			alu_sll: alu_out = ex_op_a << shamt;
			alu_slt: alu_out = {{(xlen-1){1'b0}}, lt};
			alu_sltu: alu_out = {{(xlen-1){1'b0}}, ltu};
			alu_xor: alu_out = ex_op_a ^ ex_op_b;
			alu_srl: alu_out = ex_op_a >> shamt;
			alu_sra: alu_out = $signed(ex_op_a) >>> shamt;
			alu_or: alu_out = ex_op_a | ex_op_b;
			default: alu_out = ex_op_a & ex_op_b;
		endcase
	end

	always_comb begin
		case (ex_funct3)
			f3_beq: cond = eq;
			f3_bne: cond = !eq;
			f3_blt: cond = lt;
			f3_bge: cond = !lt;
			f3_bltu: cond = ltu;
			f3_bgeu: cond = !ltu;
			default: cond = 1'b0;
		endcase
	end

	assign branch_taken = ex_valid && ex_is_branch && cond;
	assign branch_target = ex_pc + ex_imm[11:0];

	// LUI is forwarded from here before its write-back
	assign ex_result = (ex_wb_sel == sel_imm) ? ex_imm : alu_out;

	// Store block, data replicated across lanes and masked by enables
	assign byte_off = alu_out[1:0];
	always_comb begin
		case (ex_mem_size)
			size_b, size_bu: begin
				store_be = 4'b0001 << byte_off;
				dm_wdata = {4{ex_store_data[7:0]}};
			end
			size_h, size_hu: begin
				store_be = byte_off[1] ? 4'b1100 : 4'b0011;
				dm_wdata = {2{ex_store_data[15:0]}};
			end
			default: begin
				store_be = 4'b1111;
				dm_wdata = ex_store_data;
			end
		endcase
	end

	assign dm_we = (ex_valid && ex_is_store) ? store_be : '0;
	assign dm_addr = alu_out[11:2];  // Loads read at this edge too

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
			wb_wr_en <= 1'b0;
		end else begin
			wb_valid <= ex_valid;
			wb_wr_en <= ex_valid && ex_wr_en;
		end
	end

	always_ff @(posedge clk) begin
		wb_rd <= ex_rd;
		wb_wb_sel <= ex_wb_sel;
		wb_alu <= alu_out;
		wb_imm <= ex_imm;
		wb_mem_size <= ex_mem_size;
		wb_byte_off <= byte_off;     // Lane select for the load block
	end

endmodule

// ==== src/rv_result.sv ====
module rv_result (
	input  logic clk,
	input  rv_pkg::byte_en_t dm_we,
	input  rv_pkg::dmem_addr_t dm_addr,
	input  rv_pkg::word_t dm_wdata,
	input  logic wb_valid,
	input  rv_pkg::reg_addr_t wb_rd,
	input  logic wb_wr_en,
	input  rv_pkg::wb_sel_t wb_wb_sel,
	input  rv_pkg::word_t wb_alu,
	input  rv_pkg::word_t wb_imm,
	input  rv_pkg::mem_size_t wb_mem_size,
	input  logic [1:0] wb_byte_off,
	input  rv_pkg::byte_en_t con_write,
	input  rv_pkg::dmem_addr_t con_addr,
	input  rv_pkg::word_t con_in,
	output rv_pkg::word_t con_out,
	output logic rf_we,
	output rv_pkg::reg_addr_t rf_waddr,
	output rv_pkg::word_t rf_wdata
);
	import rv_pkg::*;

	word_t dmem [dmem_words];
	word_t mem_rdata;            // Core port read, valid in the result stage
	word_t shifted;              // Addressed lane moved down to bit 0
	word_t load_data;

	// Two synchronous ports, byte enabled
	always_ff @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			if (con_write[i])
				dmem[con_addr][8*i +: 8] <= con_in[8*i +: 8];
			if (dm_we[i])
				dmem[dm_addr][8*i +: 8] <= dm_wdata[8*i +: 8];  // Last, wins a collision
		end
		mem_rdata <= dmem[dm_addr];
		con_out <= dmem[con_addr];
	end

	// Load block
	assign shifted = mem_rdata >> {wb_byte_off, 3'b000};
	always_comb begin
		case (wb_mem_size)
			size_b: load_data = {{24{shifted[7]}}, shifted[7:0]};
			size_bu: load_data = {24'h000000, shifted[7:0]};
			size_h: load_data = {{16{shifted[15]}}, shifted[15:0]};
			size_hu: load_data = {16'h0000, shifted[15:0]};
			default: load_data = mem_rdata;
		endcase
	end

	always_comb begin
		case (wb_wb_sel)
			sel_imm: rf_wdata = wb_imm;
			sel_load: rf_wdata = load_data;
			default: rf_wdata = wb_alu;
		endcase
	end

	// Writes to x0 are dropped here, so forwarding never sees them
	assign rf_we = wb_valid && wb_wr_en && wb_rd != '0;
	assign rf_waddr = wb_rd;

endmodule

// ==== src/rv_core.sv ====
module rv_core (
	input  logic clk,
	input  logic rst_n,
	input  logic run,                    // High to execute, low to load a program
	input  logic prog_we,
	input  rv_pkg::pc_t prog_addr,
	input  rv_pkg::word_t prog_data,
	input  rv_pkg::byte_en_t con_write,
	input  rv_pkg::dmem_addr_t con_addr,
	input  rv_pkg::word_t con_in,
	output rv_pkg::word_t con_out        // Word at con_addr, one cycle later
);
	import rv_pkg::*;

	// Fetch to decode
	logic id_valid;
	word_t id_inst;
	pc_t id_pc;
	logic stall;

	// Decode to execute
	logic ex_valid;
	alu_op_t ex_alu_op;
	word_t ex_op_a, ex_op_b, ex_store_data, ex_imm;
	reg_addr_t ex_rd;
	logic ex_wr_en;
	wb_sel_t ex_wb_sel;
	logic ex_is_load, ex_is_store, ex_is_branch;
	logic [2:0] ex_funct3;
	mem_size_t ex_mem_size;
	pc_t ex_pc;

	// Execute back to decode and fetch
	logic branch_taken;
	pc_t branch_target;
	word_t ex_result;

	// Execute to result
	byte_en_t dm_we;
	dmem_addr_t dm_addr;
	word_t dm_wdata;
	logic wb_valid, wb_wr_en;
	reg_addr_t wb_rd;
	wb_sel_t wb_wb_sel;
	word_t wb_alu, wb_imm;
	mem_size_t wb_mem_size;
	logic [1:0] wb_byte_off;

	// Write-back into the register file and forwarding
	logic rf_we;
	reg_addr_t rf_waddr;
	word_t rf_wdata;

	rv_fetch u_fetch (.*);
	rv_decode u_decode (.*);
	rv_execute u_execute (.*);
	rv_result u_result (.*);

endmodule

// ==== testbench/core_chk.sv ====
module core_chk (
	input  logic clk,
	input  logic rst_n,
	input  rv_pkg::byte_en_t dm_we,
	input  logic stall,
	input  logic branch_taken,
	input  logic ex_valid
);

	int unsigned assert_fails = 0;       // Read by the testbench at the end

	// No store reaches memory in reset or in the first cycle out of it
	no_store_in_reset: assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |-> dm_we == '0)
		else begin
			assert_fails++;
			$error("store enable active during or just after reset");
		end

	// Load-use stall lasts exactly one cycle
	single_stall: assert property (@(posedge clk) disable iff (!rst_n) stall |=> !stall)
		else begin
			assert_fails++;
			$error("stall held for two cycles in a row");
		end

	// Younger instruction squashed
	flush_after_branch: assert property (@(posedge clk) disable iff (!rst_n)
		branch_taken |=> !ex_valid)
		else begin
			assert_fails++;
			$error("execute stage valid right after a taken branch");
		end

endmodule

bind rv_core core_chk u_chk (
	.clk(clk),
	.rst_n(rst_n),
	.dm_we(dm_we),
	.stall(stall),
	.branch_taken(branch_taken),
	.ex_valid(ex_valid)
);

// ==== testbench/tb_core.sv ====
module tb_core;
	import rv_pkg::*;

	localparam int done_word = 511;          // Byte address 2044
	localparam int done_marker = 'h5a5;
	localparam int poison = 'h7ad;           // Stored when a branch falls through
	localparam int poll_limit = 2000;        // Cycles allowed per program

	logic clk = 1'b0;
	logic rst_n;
	logic run;
	logic prog_we;
	pc_t prog_addr;
	word_t prog_data;
	byte_en_t con_write;
	dmem_addr_t con_addr;
	word_t con_in;
	word_t con_out;

	word_t prog [$];                         // Program being assembled
	int errors = 0;
	int checks = 0;

	// add sub sll slt sltu xor srl sra or and
	int reg_f3 [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
	int reg_alt [10] = '{0, 1, 0, 0, 0, 0, 0, 1, 0, 0};
	// addi slti sltiu xori ori andi slli srli srai
	// The srai entry has imm[10] set
	int imm_f3 [9] = '{0, 2, 3, 4, 6, 7, 1, 5, 5};
	int imm_val [9] = '{-5, 'h123, -1, -1883, 'h0f0, -241, 7, 9, 'h40d};
	logic [2:0] br_f3 [6] = '{f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu};
	// Worked by hand for word 0 = c3b596e7 over a 11223344 background
	word_t sub_exp [9] = '{32'h1122e744, 32'he7223344, 32'h96e73344, 32'h112296e7,
		32'hffffff96, 32'h000000c3, 32'hffffc3b5, 32'h000096e7, 32'hffff96e7};

	rv_core u_dut (.*);

	always #20 clk = ~clk;

	// Instruction formats
	function automatic word_t r_type(int f7, int rs2, int rs1, int f3, int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op_reg};
	endfunction

	function automatic word_t i_type(int imm, int rs1, int f3, int rd, logic [6:0] op);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
	endfunction

	function automatic word_t s_type(int imm, int rs2, int rs1, int f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], op_store};
	endfunction

	function automatic word_t b_type(int off, int rs2, int rs1, logic [2:0] f3);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], op_branch};
	endfunction

	function automatic word_t u_type(int imm20, int rd);
		return {imm20[19:0], rd[4:0], op_lui};
	endfunction

	// RV32I result where b is rs2 or the sign-extended immediate
	function automatic word_t alu_ref(int f3, int alt, word_t a, word_t b);
		word_t r;
		case (f3)
			0: r = (alt != 0) ? a - b : a + b;
			1: r = a << b[4:0];
			2: r = {31'b0, $signed(a) < $signed(b)};
			3: r = {31'b0, a < b};
			4: r = a ^ b;
			5: begin
				if (alt != 0)
					r = $signed(a) >>> b[4:0];   // Sign bit shifted in
				else
					r = a >> b[4:0];
			end
			6: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	function automatic logic branch_holds(logic [2:0] f3, word_t a, word_t b);
		case (f3)
			f3_beq: return a == b;
			f3_bne: return a != b;
			f3_blt: return $signed(a) < $signed(b);
			f3_bge: return $signed(a) >= $signed(b);
			f3_bltu: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#2;                                  // Drive and sample clear of the edge
	endtask

	task automatic write_word(int a, word_t d);
		con_addr = dmem_addr_t'(a);
		con_in = d;
		con_write = 4'hf;
		next_cycle();
		con_write = '0;
	endtask

	// con_out follows the address by one cycle
	task automatic read_word(int a, output word_t d);
		con_addr = dmem_addr_t'(a);
		next_cycle();
		d = con_out;
	endtask

	task automatic check_word(string name, word_t got, word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic reset_core();
		run = 1'b0;
		prog_we = 1'b0;
		con_write = '0;
		rst_n = 1'b0;
		repeat (4) next_cycle();
		rst_n = 1'b1;
	endtask

	// Appends the done sequence, loads while halted, runs until the marker shows up
	task automatic load_and_run(string name);
		int cycles;
		word_t done;
		prog.push_back(i_type(done_marker, 0, 0, 31, op_imm));
		prog.push_back(s_type(4 * done_word, 31, 0, 2));
		prog.push_back(b_type(0, 0, 0, f3_beq));       // Spin here
		reset_core();
		write_word(done_word, '0);
		foreach (prog[i]) begin
			prog_we = 1'b1;
			prog_addr = pc_t'(4 * i);
			prog_data = prog[i];
			next_cycle();
		end
		prog_we = 1'b0;
		run = 1'b1;
		con_addr = dmem_addr_t'(done_word);
		cycles = 0;
		done = '0;
		while (done !== word_t'(done_marker) && cycles < poll_limit) begin
			next_cycle();
			done = con_out;
			cycles++;
		end
		run = 1'b0;
		if (done !== word_t'(done_marker)) begin
			errors++;
			$display("Timeout: program %s never stored its done marker", name);
		end
	endtask

	task automatic reg_ops();
		word_t a, b, got;
		a = $urandom;
		b = $urandom;
		write_word(0, a);
		write_word(1, b);
		prog = {};
		prog.push_back(i_type(0, 0, 2, 1, op_load));   // lw x1, 0(x0)
		prog.push_back(i_type(4, 0, 2, 2, op_load));   // lw x2, 4(x0)
		for (int k = 0; k < 10; k++) begin
			prog.push_back(r_type(reg_alt[k] * 32, 2, 1, reg_f3[k], 3));
			prog.push_back(s_type(64 + 4 * k, 3, 0, 2));
		end
		load_and_run("reg_ops");
		for (int k = 0; k < 10; k++) begin
			read_word(16 + k, got);
			check_word($sformatf("reg op word %0d", 16 + k), got,
				alu_ref(reg_f3[k], reg_alt[k], a, b));
		end
	endtask

	task automatic imm_ops();
		word_t a, got;
		a = $urandom;
		write_word(0, a);
		prog = {};
		prog.push_back(i_type(0, 0, 2, 1, op_load));
		for (int k = 0; k < 9; k++) begin
			prog.push_back(i_type(imm_val[k], 1, imm_f3[k], 3, op_imm));
			prog.push_back(s_type(64 + 4 * k, 3, 0, 2));
		end
		prog.push_back(u_type('habcde, 5));
		prog.push_back(s_type(100, 5, 0, 2));          // Word 25
		load_and_run("imm_ops");
		for (int k = 0; k < 9; k++) begin
			read_word(16 + k, got);
			check_word($sformatf("imm op word %0d", 16 + k), got,
				alu_ref(imm_f3[k], (k == 8) ? 1 : 0, a, word_t'(imm_val[k])));
		end
		read_word(25, got);
		check_word("lui word 25", got, 32'habcde000);
	endtask

	task automatic forwarding();
		word_t a, x2, x3, x4, x5, got;
		a = $urandom;
		write_word(0, a);
		prog = {};
		prog.push_back(i_type(0, 0, 2, 1, op_load));   // lw x1
		prog.push_back(i_type(1, 1, 0, 2, op_imm));    // Load used at once
		prog.push_back(r_type(0, 2, 2, 0, 3));         // add x3, x2, x2
		prog.push_back(r_type(32, 1, 3, 0, 4));        // sub x4, x3, x1
		prog.push_back(r_type(0, 2, 4, 4, 5));         // xor x5, x4, x2
		prog.push_back(s_type(64, 5, 0, 2));
		prog.push_back(r_type(0, 3, 5, 0, 8));         // x5 two back comes from write-back
		prog.push_back(s_type(76, 8, 0, 2));
		prog.push_back(i_type(64, 0, 2, 6, op_load));
		prog.push_back(s_type(68, 6, 0, 2));           // Load into store data
		prog.push_back(u_type('h12345, 7));
		prog.push_back(i_type('h678, 7, 0, 7, op_imm));
		prog.push_back(s_type(72, 7, 0, 2));
		load_and_run("forwarding");
		x2 = a + 1;
		x3 = x2 + x2;
		x4 = x3 - a;
		x5 = x4 ^ x2;
		read_word(16, got);
		check_word("chain word 16", got, x5);
		read_word(17, got);
		check_word("reload word 17", got, x5);
		read_word(18, got);
		check_word("lui addi word 18", got, 32'h12345678);
		read_word(19, got);
		check_word("chain word 19", got, x5 + x3);
	endtask

	task automatic branches();
		word_t a, b, got;
		a = $urandom | 32'h8000_0000;       // Negative signed and large unsigned
		b = $urandom & 32'h7fff_ffff;
		write_word(0, a);
		write_word(1, b);
		for (int i = 0; i < 12; i++)
			write_word(32 + i, '0);
		prog = {};
		prog.push_back(i_type(0, 0, 2, 1, op_load));
		prog.push_back(i_type(4, 0, 2, 2, op_load));
		prog.push_back(i_type(0, 0, 2, 3, op_load));   // x3 equals x1
		prog.push_back(i_type(poison, 0, 0, 9, op_imm));
		for (int p = 0; p < 2; p++) begin
			for (int c = 0; c < 6; c++) begin
				prog.push_back(b_type(8, (p == 0) ? 2 : 3, 1, br_f3[c]));
				prog.push_back(s_type(128 + 4 * (6 * p + c), 9, 0, 2));
			end
		end
		load_and_run("branches");
		for (int p = 0; p < 2; p++) begin
			for (int c = 0; c < 6; c++) begin
				read_word(32 + 6 * p + c, got);
				check_word($sformatf("branch slot word %0d", 32 + 6 * p + c), got,
					branch_holds(br_f3[c], a, (p == 0) ? b : a) ? '0 : word_t'(poison));
			end
		end
	endtask

	task automatic sub_word();
		word_t got;
		write_word(0, 32'hc3b596e7);
		for (int i = 0; i < 4; i++)
			write_word(80 + i, 32'h11223344);
		prog = {};
		prog.push_back(i_type(0, 0, 2, 1, op_load));
		prog.push_back(s_type(321, 1, 0, 0));          // sb to word 80 lane 1
		prog.push_back(s_type(327, 1, 0, 0));          // sb to word 81 lane 3
		prog.push_back(s_type(330, 1, 0, 1));          // sh to word 82 upper half
		prog.push_back(s_type(332, 1, 0, 1));          // sh to word 83 lower half
		prog.push_back(i_type(1, 0, 0, 2, op_load));   // lb
		prog.push_back(i_type(3, 0, 4, 3, op_load));   // lbu
		prog.push_back(i_type(2, 0, 1, 4, op_load));   // lh
		prog.push_back(i_type(0, 0, 5, 5, op_load));   // lhu
		prog.push_back(i_type(0, 0, 1, 6, op_load));   // lh of a negative half
		for (int r = 2; r <= 6; r++)
			prog.push_back(s_type(336 + 4 * (r - 2), r, 0, 2));
		load_and_run("sub_word");
		for (int k = 0; k < 9; k++) begin
			read_word(80 + k, got);
			check_word($sformatf("byte half word %0d", 80 + k), got, sub_exp[k]);
		end
	endtask

	initial begin
		rst_n = 1'b0;
		run = 1'b0;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		con_write = '0;
		con_addr = '0;
		con_in = '0;
		void'($urandom(32'ha12));
		reg_ops();
		imm_ops();
		forwarding();
		branches();
		sub_word();
		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
			u_dut.u_chk.assert_fails);
		if (errors == 0 && u_dut.u_chk.assert_fails == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== build.f ====
src/rv_pkg.sv
src/rv_fetch.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_result.sv
src/rv_core.sv
testbench/core_chk.sv
testbench/tb_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_core
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
SIM_ARGS ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build the testbench with Verilator, run it, check the log"
	@echo "  clean  remove build output and the log"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Failure reported in $(LOG)"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
